/* ifmap_buffer.f */
src/ifmap_cfg_pkg.sv
src/ifmap_data_pkg.sv
src/bank_wr_if.sv
src/layer_cfg_reg.sv
src/bank_fill_ctrl.sv
src/ifmap_bank.sv
src/pingpong_ctrl.sv
src/ifmap_buffer.sv
testbench/ifmap_buffer_sva.sv
testbench/ifmap_checker.sv
testbench/tb_ifmap_buffer.sv

/* Bender.yml */
package:
  name: ifmap_buffer

sources:
  - files:
      - src/ifmap_cfg_pkg.sv
      - src/ifmap_data_pkg.sv
      - src/bank_wr_if.sv
      - src/layer_cfg_reg.sv
      - src/bank_fill_ctrl.sv
      - src/ifmap_bank.sv
      - src/pingpong_ctrl.sv
      - src/ifmap_buffer.sv
  - target: test
    files:
      - testbench/ifmap_buffer_sva.sv
      - testbench/ifmap_checker.sv
      - testbench/tb_ifmap_buffer.sv

/* testbench/tb_ifmap_buffer.sv */
module tb_ifmap_buffer;
    timeunit 1ns;
    timeprecision 1ps;

    // one spare line keeps the bytes past the last layer1 line visible
    localparam int MAX_LINES = 10;
    localparam int MAX_ELEMS = 24;

    logic                                                 clk;
    logic                                                 rst_n;
    logic                                                 start;
    logic                                                 start_layer;
    ifmap_cfg_pkg::layer_type_t                           layer_type_in;
    logic                                                 pkt_valid;
    ifmap_data_pkg::pkt_mask_t                            pkt_mask;
    ifmap_data_pkg::pkt_data_t                            pkt_data;
    logic                                                 decompressor_ack;
    logic                                                 free_ifmap_buffer;
    logic                                                 ifmap_buffer_req;
    ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] ifmap_data;
    logic                                                 ifmap_data_valid;
    logic                                                 ifmap_data_change;
    int                                                   error_count;
    int                                                   timeout_count;
    int                                                   sva_fails;

    ifmap_buffer #(.MAX_LINES(MAX_LINES), .MAX_ELEMS(MAX_ELEMS)) dut_i (.*);

    ifmap_checker #(.MAX_LINES(MAX_LINES), .MAX_ELEMS(MAX_ELEMS)) chk_i (.*);

    bind pingpong_ctrl ifmap_buffer_sva sva_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .enq_sel           (enq_sel),
        .deq_sel           (deq_sel),
        .full              (full),
        .free_ifmap_buffer (free_ifmap_buffer),
        .ifmap_buffer_req  (ifmap_buffer_req)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // contiguous mask of 1..8 lanes, random valid, ack gaps and frees
    task automatic drive_packet();
        int n;
        n = $urandom_range(1, 8);
        pkt_mask = 8'hff >> (8 - n);
        pkt_valid = $urandom_range(0, 4) != 0;
        pkt_data = {$urandom, $urandom};
        decompressor_ack = $urandom_range(0, 2) != 0;
        free_ifmap_buffer = $urandom_range(0, 9) == 0;
    endtask

    task automatic run_layer(input ifmap_cfg_pkg::layer_type_t lt, input int banks);
        int cycles;
        int shown;
        start = 1'b1;
        start_layer = 1'b1;
        layer_type_in = lt;
        next_cycle();
        start = 1'b0;
        start_layer = 1'b0;
        cycles = 0;
        shown = 0;
        // each completed bank is presented once with a change pulse
        while ((shown < banks) && (cycles < 3000)) begin
            drive_packet();
            next_cycle();
            if (ifmap_data_change) begin
                shown++;
            end
            cycles++;
        end
        if (shown < banks) begin
            $display("timeout: %s presented %0d of %0d banks", lt.name(), shown, banks);
            timeout_count++;
        end
        // past stop the request has to stay low
        repeat (30) begin
            drive_packet();
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(32'hb354_4989));
        rst_n = 1'b0;
        start = 1'b0;
        start_layer = 1'b0;
        layer_type_in = ifmap_cfg_pkg::layer_null;
        pkt_valid = 1'b0;
        pkt_mask = '0;
        pkt_data = '0;
        decompressor_ack = 1'b0;
        free_ifmap_buffer = 1'b0;
        timeout_count = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) next_cycle();
        run_layer(ifmap_cfg_pkg::layer1, 3);
        run_layer(ifmap_cfg_pkg::layer2, 1);
        run_layer(ifmap_cfg_pkg::layer3, 1);
        run_layer(ifmap_cfg_pkg::layer1, 3);
        next_cycle();
        sva_fails = dut_i.u_pingpong.sva_i.fail_count;
        $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
                 error_count, sva_fails, timeout_count);
        if ((error_count == 0) && (sva_fails == 0) && (timeout_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/ifmap_checker.sv */
module ifmap_checker #(
    parameter int MAX_LINES = 9,
    parameter int MAX_ELEMS = 24
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 start,
    input  logic                                                 start_layer,
    input  ifmap_cfg_pkg::layer_type_t                           layer_type_in,
    input  logic                                                 pkt_valid,
    input  ifmap_data_pkg::pkt_mask_t                            pkt_mask,
    input  ifmap_data_pkg::pkt_data_t                            pkt_data,
    input  logic                                                 decompressor_ack,
    input  logic                                                 free_ifmap_buffer,
    input  logic                                                 ifmap_buffer_req,
    input  ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] ifmap_data,
    input  logic                                                 ifmap_data_valid,
    input  logic                                                 ifmap_data_change,
    output int                                                   error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_W = MAX_LINES * MAX_ELEMS * 8;
    typedef ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] image_t;

    // geometry indexed by layer type: null, layer1, layer2, layer3
    int elems_tab [4] = '{0, 20, 11, 9};
    int lines_tab [4] = '{0, 9, 6, 4};
    int banks_tab [4] = '{0, 3, 1, 1};

    image_t img [2];
    int     elem_ptr [2];
    int     line_ptr [2];
    int     lt;
    // bank numbers, -1 for none
    int     enq;
    int     deq;
    int     deq_q;
    int     free_bank;
    // completed banks of the current layer
    int     fill_count;

    task automatic check_value(input string name, input logic [IMG_W-1:0] exp,
                               input logic [IMG_W-1:0] act);
        if (exp !== act) begin
            error_count++;
            $display("error %s at %0t: expected %0h actual %0h", name, $time, exp, act);
        end
    endtask

    // compare mid-cycle, then step the model with the inputs of the coming edge
    always @(negedge clk) begin
        int     elems;
        int     lines;
        int     cnt;
        int     pos;
        int     ln;
        int     enq_n;
        int     deq_n;
        int     free_n;
        bit     full [2];
        bit     stop;
        bit     req;
        bit     done;
        image_t exp_img;
        if (!rst_n) begin
            img[0] = '0;
            img[1] = '0;
            elem_ptr = '{0, 0};
            line_ptr = '{0, 0};
            lt = 0;
            enq = -1;
            deq = -1;
            deq_q = -1;
            free_bank = -1;
            fill_count = 0;
        end else begin
            elems = elems_tab[lt];
            lines = lines_tab[lt];
            for (int b = 0; b < 2; b++) begin
                full[b] = (lines != 0) && (line_ptr[b] == lines);
            end
            stop = fill_count == banks_tab[lt];
            req = (enq >= 0) && !full[enq] && !stop && (free_bank < 0);
            exp_img = (deq >= 0) ? img[deq] : '0;
            check_value("request", req, ifmap_buffer_req);
            check_value("data_valid", deq >= 0, ifmap_data_valid);
            check_value("data_change", (deq >= 0) && (deq != deq_q), ifmap_data_change);
            check_value("image", exp_img, ifmap_data);

            done = 1'b0;
            if (req && decompressor_ack) begin
                cnt = 0;
                for (int i = 0; i < 8; i++) begin
                    if (pkt_valid && pkt_mask[i]) begin
                        pos = elem_ptr[enq] + i;
                        ln = line_ptr[enq];
                        // past the line end the byte starts the next line
                        if (pos >= elems) begin
                            pos -= elems;
                            ln++;
                        end
                        if (ln < MAX_LINES) begin
                            img[enq][ln][pos] = pkt_data[i];
                        end
                        cnt++;
                    end
                end
                pos = elem_ptr[enq] + cnt;
                if (pos >= elems) begin
                    elem_ptr[enq] = pos - elems;
                    line_ptr[enq]++;
                end else begin
                    elem_ptr[enq] = pos;
                end
                done = line_ptr[enq] == lines;
            end

            // enqueue keeps its bank until it is full, then moves to the other one
            if (start || (full[0] && full[1])) begin
                enq_n = -1;
            end else if (full[0] != full[1]) begin
                enq_n = full[0] ? 1 : 0;
            end else if (enq < 0) begin
                enq_n = 0;
            end else begin
                enq_n = enq;
            end
            if (start || (!full[0] && !full[1])) begin
                deq_n = -1;
            end else if (full[0] != full[1]) begin
                deq_n = full[0] ? 0 : 1;
            end else begin
                deq_n = deq;
            end
            free_n = -1;
            if (!start && free_ifmap_buffer && (deq >= 0) && full[deq]) begin
                free_n = deq;
            end
            if (start) begin
                fill_count = 0;
            end else if (done && !stop) begin
                fill_count++;
            end
            for (int b = 0; b < 2; b++) begin
                if (start || (free_bank == b)) begin
                    img[b] = '0;
                    elem_ptr[b] = 0;
                    line_ptr[b] = 0;
                end
            end
            deq_q = deq;
            enq = enq_n;
            deq = deq_n;
            free_bank = free_n;
            if (start_layer) begin
                lt = int'(layer_type_in);
            end
        end
    end

endmodule

/* testbench/ifmap_buffer_sva.sv */
module ifmap_buffer_sva (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  ifmap_data_pkg::bank_sel_t  enq_sel,
    input  ifmap_data_pkg::bank_sel_t  deq_sel,
    input  ifmap_data_pkg::bank_sel_t  full,
    input  logic                       free_ifmap_buffer,
    input  logic                       ifmap_buffer_req
);
    timeunit 1ns;
    timeprecision 1ps;

    // read back by the testbench top for the closing line
    int fail_count = 0;

    // at most one bank takes packets
    enq_onehot: assert property (@(posedge clk) disable iff (!rst_n) !(&enq_sel))
        else begin
            fail_count++;
            $error("enqueue selects both banks");
        end

    // the presented bank is never the one being filled
    deq_not_enq: assert property (@(posedge clk) disable iff (!rst_n)
        (deq_sel & enq_sel) == '0)
        else begin
            fail_count++;
            $error("dequeue bank is also the enqueue bank");
        end

    // a free of the presented full bank holds the request low while its pulse is active
    no_req_in_free: assert property (@(posedge clk) disable iff (!rst_n)
        (!start && free_ifmap_buffer && ((deq_sel & full) != '0)) |=> !ifmap_buffer_req)
        else begin
            fail_count++;
            $error("request is high during a free pulse");
        end

endmodule

/* src/ifmap_buffer.sv */
module ifmap_buffer #(
    parameter int MAX_LINES = 9,
    parameter int MAX_ELEMS = 24
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 start,
    input  logic                                                 start_layer,
    input  ifmap_cfg_pkg::layer_type_t                           layer_type_in,
    input  logic                                                 pkt_valid,
    input  ifmap_data_pkg::pkt_mask_t                            pkt_mask,
    input  ifmap_data_pkg::pkt_data_t                            pkt_data,
    input  logic                                                 decompressor_ack,
    input  logic                                                 free_ifmap_buffer,
    output logic                                                 ifmap_buffer_req,
    output ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] ifmap_data,
    output logic                                                 ifmap_data_valid,
    output logic                                                 ifmap_data_change
);

    logic [ifmap_cfg_pkg::ELEM_W-1:0]                       elems;
    logic [ifmap_cfg_pkg::LINE_W-1:0]                       lines;
    logic [ifmap_cfg_pkg::BANK_W-1:0]                       bank_target;
    logic                                                   full0;
    logic                                                   full1;
    logic                                                   done0;
    logic                                                   done1;
    logic                                                   handshake;
    ifmap_data_pkg::bank_sel_t                              enq_sel;
    ifmap_data_pkg::bank_sel_t                              free_pulse;
    ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0]   bank_data0;
    ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0]   bank_data1;

    bank_wr_if wr0 ();
    bank_wr_if wr1 ();

    layer_cfg_reg u_cfg (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_layer   (start_layer),
        .layer_type_in (layer_type_in),
        .layer_type    (),
        .elems         (elems),
        .lines         (lines),
        .bank_target   (bank_target)
    );

    bank_fill_ctrl u_fill0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .enq_sel    (enq_sel[0]),
        .handshake  (handshake),
        .free_pulse (free_pulse[0]),
        .pkt_valid  (pkt_valid),
        .pkt_mask   (pkt_mask),
        .pkt_data   (pkt_data),
        .elems      (elems),
        .lines      (lines),
        .full       (full0),
        .done_pulse (done0),
        .wr         (wr0.filler)
    );

    bank_fill_ctrl u_fill1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .enq_sel    (enq_sel[1]),
        .handshake  (handshake),
        .free_pulse (free_pulse[1]),
        .pkt_valid  (pkt_valid),
        .pkt_mask   (pkt_mask),
        .pkt_data   (pkt_data),
        .elems      (elems),
        .lines      (lines),
        .full       (full1),
        .done_pulse (done1),
        .wr         (wr1.filler)
    );

    ifmap_bank #(
        .MAX_LINES (MAX_LINES),
        .MAX_ELEMS (MAX_ELEMS)
    ) u_bank0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .elems     (elems),
        .wr        (wr0.store),
        .bank_data (bank_data0)
    );

    ifmap_bank #(
        .MAX_LINES (MAX_LINES),
        .MAX_ELEMS (MAX_ELEMS)
    ) u_bank1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .elems     (elems),
        .wr        (wr1.store),
        .bank_data (bank_data1)
    );

    pingpong_ctrl #(
        .MAX_LINES (MAX_LINES),
        .MAX_ELEMS (MAX_ELEMS)
    ) u_pingpong (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .full0             (full0),
        .full1             (full1),
        .done0             (done0),
        .done1             (done1),
        .bank_target       (bank_target),
        .decompressor_ack  (decompressor_ack),
        .free_ifmap_buffer (free_ifmap_buffer),
        .bank_data0        (bank_data0),
        .bank_data1        (bank_data1),
        .enq_sel           (enq_sel),
        .free_pulse        (free_pulse),
        .handshake         (handshake),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .ifmap_data        (ifmap_data),
        .ifmap_data_valid  (ifmap_data_valid),
        .ifmap_data_change (ifmap_data_change)
    );

endmodule

/* src/pingpong_ctrl.sv */
module pingpong_ctrl #(
    parameter int MAX_LINES = 9,
    parameter int MAX_ELEMS = 24
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 start,
    input  logic                                                 full0,
    input  logic                                                 full1,
    input  logic                                                 done0,
    input  logic                                                 done1,
    input  logic [ifmap_cfg_pkg::BANK_W-1:0]                     bank_target,
    input  logic                                                 decompressor_ack,
    input  logic                                                 free_ifmap_buffer,
    input  ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] bank_data0,
    input  ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] bank_data1,
    output ifmap_data_pkg::bank_sel_t                            enq_sel,
    output ifmap_data_pkg::bank_sel_t                            free_pulse,
    output logic                                                 handshake,
    output logic                                                 ifmap_buffer_req,
    output ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] ifmap_data,
    output logic                                                 ifmap_data_valid,
    output logic                                                 ifmap_data_change
);

    ifmap_data_pkg::bank_sel_t              full;
    ifmap_data_pkg::bank_sel_t              deq_sel;
    ifmap_data_pkg::bank_sel_t              deq_sel_q;
    logic [ifmap_cfg_pkg::BANK_W-1:0]       fill_cnt;
    logic                                   stop;

    assign full = {full1, full0};

    // enqueue stays on its bank until that bank fills, none while both are full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq_sel <= '0;
        end else if (start || (&full)) begin
            enq_sel <= '0;
        end else if (^full) begin
            enq_sel <= ~full;
        end else if (enq_sel == '0) begin
            enq_sel <= 2'b01;
        end
    end

    // with both banks full the presented bank is kept until freed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deq_sel <= '0;
        end else if (start || (full == '0)) begin
            deq_sel <= '0;
        end else if (^full) begin
            deq_sel <= full;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_pulse <= '0;
        end else if (start) begin
            free_pulse <= '0;
        end else if (free_ifmap_buffer) begin
            free_pulse <= deq_sel & full;
        end else begin
            free_pulse <= '0;
        end
    end

    // completed banks this layer, saturating at the target
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (start) begin
            fill_cnt <= '0;
        end else if ((done0 || done1) && !stop) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign stop = fill_cnt == bank_target;

    assign ifmap_buffer_req = (|(enq_sel & ~full)) && !stop && !(|free_pulse);
    assign handshake        = ifmap_buffer_req & decompressor_ack;

    assign ifmap_data = deq_sel[0] ? bank_data0 :
                        deq_sel[1] ? bank_data1 : '0;
    assign ifmap_data_valid = |deq_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deq_sel_q <= '0;
        end else begin
            deq_sel_q <= deq_sel;
        end
    end

    // one cycle pulse whenever a new bank is presented
    assign ifmap_data_change = ifmap_data_valid && (deq_sel != deq_sel_q);

endmodule

/* src/ifmap_bank.sv */
module ifmap_bank #(
    parameter int MAX_LINES = 9,
    parameter int MAX_ELEMS = 24
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [ifmap_cfg_pkg::ELEM_W-1:0]                    elems,
    bank_wr_if.store                                            wr,
    output ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] bank_data
);

    ifmap_data_pkg::byte_t [MAX_LINES-1:0][MAX_ELEMS-1:0] mem;

    // per lane target position after the wrap rule
    logic [ifmap_cfg_pkg::ELEM_W:0]     lane_pos  [ifmap_data_pkg::PKT_BYTES];
    logic [ifmap_cfg_pkg::LINE_W:0]     lane_line [ifmap_data_pkg::PKT_BYTES];
    logic [ifmap_cfg_pkg::ELEM_W:0]     lane_col  [ifmap_data_pkg::PKT_BYTES];
    logic [ifmap_data_pkg::PKT_BYTES-1:0] lane_en;

    always_comb begin
        for (int i = 0; i < ifmap_data_pkg::PKT_BYTES; i++) begin
            lane_pos[i] = {1'b0, wr.elem} + (ifmap_cfg_pkg::ELEM_W + 1)'(i);
            if (lane_pos[i] < {1'b0, elems}) begin
                lane_line[i] = {1'b0, wr.line};
                lane_col[i]  = lane_pos[i];
            end else begin
                // spills into the start of the next line
                lane_line[i] = {1'b0, wr.line} + 1'b1;
                lane_col[i]  = lane_pos[i] - {1'b0, elems};
            end
            // lanes past the last stored line are dropped
            lane_en[i] = wr.wen && wr.mask[i] &&
                         (lane_line[i] < MAX_LINES) && (lane_col[i] < MAX_ELEMS);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '0;
        end else if (wr.clear) begin
            mem <= '0;
        end else begin
            for (int i = 0; i < ifmap_data_pkg::PKT_BYTES; i++) begin
                if (lane_en[i]) begin
                    mem[lane_line[i]][lane_col[i]] <= wr.data[i];
                end
            end
        end
    end

    assign bank_data = mem;

endmodule

/* src/bank_fill_ctrl.sv */
module bank_fill_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                enq_sel,
    input  logic                                handshake,
    input  logic                                free_pulse,
    input  logic                                pkt_valid,
    input  ifmap_data_pkg::pkt_mask_t           pkt_mask,
    input  ifmap_data_pkg::pkt_data_t           pkt_data,
    input  logic [ifmap_cfg_pkg::ELEM_W-1:0]    elems,
    input  logic [ifmap_cfg_pkg::LINE_W-1:0]    lines,
    output logic                                full,
    output logic                                done_pulse,
    bank_wr_if.filler                           wr
);

    logic [ifmap_cfg_pkg::ELEM_W-1:0]   elem_ptr;
    logic [ifmap_cfg_pkg::LINE_W-1:0]   line_ptr;
    logic [ifmap_cfg_pkg::ELEM_W-1:0]   elem_next;
    logic [ifmap_cfg_pkg::LINE_W-1:0]   line_next;
    // one extra bit so pointer + count cannot overflow
    logic [ifmap_cfg_pkg::ELEM_W:0]     elem_sum;
    logic                               wrap;
    logic                               wr_go;
    ifmap_data_pkg::pkt_mask_t          lane_mask;
    ifmap_data_pkg::byte_cnt_t          byte_cnt;

    // an invalid packet contributes no lanes
    assign lane_mask = pkt_mask & {ifmap_data_pkg::PKT_BYTES{pkt_valid}};

    always_comb begin
        byte_cnt = '0;
        for (int i = 0; i < ifmap_data_pkg::PKT_BYTES; i++) begin
            byte_cnt = byte_cnt + ifmap_data_pkg::CNT_W'(lane_mask[i]);
        end
    end

    assign elem_sum  = {1'b0, elem_ptr} + (ifmap_cfg_pkg::ELEM_W + 1)'(byte_cnt);
    assign wrap      = elem_sum >= {1'b0, elems};
    // a packet never spans more than one line end
    assign elem_next = wrap ? ifmap_cfg_pkg::ELEM_W'(elem_sum - {1'b0, elems})
                            : ifmap_cfg_pkg::ELEM_W'(elem_sum);
    assign line_next = wrap ? line_ptr + 1'b1 : line_ptr;

    // layer_null has zero lines and never counts as full
    assign full  = (lines != '0) && (line_ptr == lines);
    assign wr_go = enq_sel & handshake & ~full;

    // the handshake that moves the line pointer onto the line count
    assign done_pulse = wr_go && (line_next == lines);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_ptr <= '0;
            line_ptr <= '0;
        end else if (start || free_pulse) begin
            elem_ptr <= '0;
            line_ptr <= '0;
        end else if (wr_go) begin
            elem_ptr <= elem_next;
            line_ptr <= line_next;
        end
    end

    assign wr.wen   = wr_go;
    assign wr.line  = line_ptr;
    assign wr.elem  = elem_ptr;
    assign wr.data  = pkt_data;
    assign wr.mask  = lane_mask;
    assign wr.clear = start | free_pulse;

endmodule

/* src/layer_cfg_reg.sv */
module layer_cfg_reg (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start_layer,
    input  ifmap_cfg_pkg::layer_type_t          layer_type_in,
    output ifmap_cfg_pkg::layer_type_t          layer_type,
    output logic [ifmap_cfg_pkg::ELEM_W-1:0]    elems,
    output logic [ifmap_cfg_pkg::LINE_W-1:0]    lines,
    output logic [ifmap_cfg_pkg::BANK_W-1:0]    bank_target
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_type <= ifmap_cfg_pkg::layer_null;
        end else if (start_layer) begin
            layer_type <= layer_type_in;
        end
    end

    // the only place where the layer is decoded into its geometry
    assign elems       = ifmap_cfg_pkg::elems_of(layer_type);
    assign lines       = ifmap_cfg_pkg::lines_of(layer_type);
    assign bank_target = ifmap_cfg_pkg::banks_of(layer_type);

endmodule

/* src/bank_wr_if.sv */
interface bank_wr_if;

    // write strobe for the masked lanes of one packet
    logic                              wen;
    // current line and element pointers of the bank
    logic [ifmap_cfg_pkg::LINE_W-1:0]  line;
    logic [ifmap_cfg_pkg::ELEM_W-1:0]  elem;
    ifmap_data_pkg::pkt_data_t         data;
    ifmap_data_pkg::pkt_mask_t         mask;
    // zeroes the whole bank
    logic                              clear;

    modport filler (
        output wen, line, elem, data, mask, clear
    );

    modport store (
        input wen, line, elem, data, mask, clear
    );

endinterface

/* src/ifmap_data_pkg.sv */
package ifmap_data_pkg;

    // byte lanes per decompressor packet
    localparam int PKT_BYTES = 8;
    // enough bits to count 0..PKT_BYTES valid lanes
    localparam int CNT_W = $clog2(PKT_BYTES + 1);

    typedef logic [7:0] byte_t;

    // valid lanes are contiguous from bit 0
    typedef logic [PKT_BYTES-1:0] pkt_mask_t;

    // lane i holds the byte for element pointer + i
    typedef byte_t [PKT_BYTES-1:0] pkt_data_t;

    typedef logic [CNT_W-1:0] byte_cnt_t;

    // one-hot or zero, bit 0 is bank 0
    typedef logic [1:0] bank_sel_t;

endpackage

/* src/ifmap_cfg_pkg.sv */
package ifmap_cfg_pkg;

    typedef enum logic [1:0] {
        layer_null = 2'd0,
        layer1     = 2'd1,
        layer2     = 2'd2,
        layer3     = 2'd3
    } layer_type_t;

    // write pointer widths
    localparam int ELEM_W = 5;
    localparam int LINE_W = 4;
    // wide enough for the largest banks-per-layer count
    localparam int BANK_W = 2;

    // scaled down layer geometry
    localparam int L1_ELEMS = 20;
    localparam int L1_LINES = 9;
    localparam int L1_BANKS = 3;
    localparam int L2_ELEMS = 11;
    localparam int L2_LINES = 6;
    localparam int L2_BANKS = 1;
    localparam int L3_ELEMS = 9;
    localparam int L3_LINES = 4;
    localparam int L3_BANKS = 1;

    function automatic logic [ELEM_W-1:0] elems_of(layer_type_t lt);
        case (lt)
            layer1:  return ELEM_W'(L1_ELEMS);
            layer2:  return ELEM_W'(L2_ELEMS);
            layer3:  return ELEM_W'(L3_ELEMS);
            default: return '0;
        endcase
    endfunction

    function automatic logic [LINE_W-1:0] lines_of(layer_type_t lt);
        case (lt)
            layer1:  return LINE_W'(L1_LINES);
            layer2:  return LINE_W'(L2_LINES);
            layer3:  return LINE_W'(L3_LINES);
            default: return '0;
        endcase
    endfunction

    function automatic logic [BANK_W-1:0] banks_of(layer_type_t lt);
        case (lt)
            layer1:  return BANK_W'(L1_BANKS);
            layer2:  return BANK_W'(L2_BANKS);
            layer3:  return BANK_W'(L3_BANKS);
            default: return '0;
        endcase
    endfunction

endpackage
